/* Makefile */
TB_TOP = tb_dbg_preload

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -sv --top-module $(TB_TOP) \
		-f dbg_preload_top.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* dbg_preload_top.f */
src/dm_regs_pkg.sv
src/sys_bus_pkg.sv
src/dmi_front.sv
src/sba_engine.sv
src/hart_ctl.sv
src/dmi_resp_merge.sv
src/dbg_sram.sv
src/dbg_preload_top.sv
tests/tb_dbg_preload.sv

/* src/dbg_preload_top.sv */
`timescale 1ns/100ps

module dbg_preload_top import dm_regs_pkg::*, sys_bus_pkg::*; #(
   parameter int credit_count = 2,
   parameter int mem_words    = 256
) (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic        dmi_req_valid_i,
   input  dmi_addr_t   dmi_req_addr_i,
   input  logic        dmi_req_write_i,
   input  logic [31:0] dmi_req_data_i,
   output logic        dmi_credit_o,
   output logic        dmi_rsp_valid_o,
   output logic [31:0] dmi_rsp_data_o,
   output logic        hart_halted_o,
   output logic        hart_resume_o,
   output logic [31:0] hart_pc_o
);

   localparam int mem_aw = $clog2(mem_words);

   // Dispatch bus
   logic              disp_valid;
   dmi_target_e       disp_target;
   dmi_addr_t         disp_addr;
   logic              disp_write;
   logic [31:0]       disp_data;

   // Unit state toward the merger
   logic              sb_busy;
   logic [31:0]       sbcs;
   sb_addr_t          sbaddress;
   sb_data_t          sbdata;
   logic [31:0]       data0;
   logic [31:0]       dmcontrol;
   logic [2:0]        cmderr;

   // Memory port
   logic              mem_en;
   logic              mem_we;
   logic [mem_aw-1:0] mem_addr;
   sb_data_t          mem_wdata;
   sb_data_t          mem_rdata;

   dmi_front #(
      .credit_count (credit_count)
   ) i_front (
      .clk_sys         (clk_sys),
      .reset_i         (reset_i),
      .dmi_req_valid_i (dmi_req_valid_i),
      .dmi_req_addr_i  (dmi_req_addr_i),
      .dmi_req_write_i (dmi_req_write_i),
      .dmi_req_data_i  (dmi_req_data_i),
      .sb_busy_i       (sb_busy),
      .dmi_credit_o    (dmi_credit_o),
      .disp_valid_o    (disp_valid),
      .disp_target_o   (disp_target),
      .disp_addr_o     (disp_addr),
      .disp_write_o    (disp_write),
      .disp_data_o     (disp_data)
   );

   sba_engine #(
      .mem_words (mem_words)
   ) i_sba (
      .clk_sys       (clk_sys),
      .reset_i       (reset_i),
      .disp_valid_i  (disp_valid),
      .disp_target_i (disp_target),
      .disp_addr_i   (disp_addr),
      .disp_write_i  (disp_write),
      .disp_data_i   (disp_data),
      .mem_rdata_i   (mem_rdata),
      .sb_busy_o     (sb_busy),
      .sbcs_o        (sbcs),
      .sbaddress_o   (sbaddress),
      .sbdata_o      (sbdata),
      .mem_en_o      (mem_en),
      .mem_we_o      (mem_we),
      .mem_addr_o    (mem_addr),
      .mem_wdata_o   (mem_wdata)
   );

   hart_ctl i_hart (
      .clk_sys       (clk_sys),
      .reset_i       (reset_i),
      .disp_valid_i  (disp_valid),
      .disp_target_i (disp_target),
      .disp_addr_i   (disp_addr),
      .disp_write_i  (disp_write),
      .disp_data_i   (disp_data),
      .hart_halted_o (hart_halted_o),
      .hart_resume_o (hart_resume_o),
      .hart_pc_o     (hart_pc_o),
      .data0_o       (data0),
      .dmcontrol_o   (dmcontrol),
      .cmderr_o      (cmderr)
   );

   dmi_resp_merge i_merge (
      .clk_sys         (clk_sys),
      .reset_i         (reset_i),
      .disp_valid_i    (disp_valid),
      .disp_addr_i     (disp_addr),
      .disp_write_i    (disp_write),
      .sb_busy_i       (sb_busy),
      .sbcs_i          (sbcs),
      .sbaddress_i     (sbaddress),
      .sbdata_i        (sbdata),
      .hart_halted_i   (hart_halted_o),
      .data0_i         (data0),
      .dmcontrol_i     (dmcontrol),
      .cmderr_i        (cmderr),
      .dmi_rsp_valid_o (dmi_rsp_valid_o),
      .dmi_rsp_data_o  (dmi_rsp_data_o)
   );

   dbg_sram #(
      .mem_words (mem_words)
   ) i_sram (
      .clk_sys     (clk_sys),
      .mem_en_i    (mem_en),
      .mem_we_i    (mem_we),
      .mem_addr_i  (mem_addr),
      .mem_wdata_i (mem_wdata),
      .mem_rdata_o (mem_rdata)
   );

endmodule

/* src/dbg_sram.sv */
`timescale 1ns/100ps

module dbg_sram import sys_bus_pkg::*; #(
   parameter int mem_words = 256
) (
   input  logic                         clk_sys,
   input  logic                         mem_en_i,
   input  logic                         mem_we_i,
   input  logic [$clog2(mem_words)-1:0] mem_addr_i,
   input  sb_data_t                     mem_wdata_i,
   output sb_data_t                     mem_rdata_o
);

   sb_data_t mem [mem_words];

   // Read data follows one cycle after the request
   always_ff @(posedge clk_sys) begin
      if (mem_en_i) begin
         if (mem_we_i) begin
            mem[mem_addr_i] <= mem_wdata_i;
         end else begin
            mem_rdata_o <= mem[mem_addr_i];
         end
      end
   end

endmodule

/* src/dm_regs_pkg.sv */
package dm_regs_pkg;

   // DMI register address
   typedef logic [6:0] dmi_addr_t;

   // Register map, debug spec locations
   localparam dmi_addr_t dm_data0      = 7'h04;
   localparam dmi_addr_t dm_dmcontrol  = 7'h10;
   localparam dmi_addr_t dm_dmstatus   = 7'h11;
   localparam dmi_addr_t dm_abstractcs = 7'h16;
   localparam dmi_addr_t dm_command    = 7'h17;
   localparam dmi_addr_t dm_sbcs       = 7'h38;
   localparam dmi_addr_t dm_sbaddress0 = 7'h39;
   localparam dmi_addr_t dm_sbdata0    = 7'h3c;

   // SBCS, bits 21 down to 12 carry the supported fields
   typedef struct packed {
      logic [9:0]  zero_hi;
      logic        sbbusy;
      logic        sbreadonaddr;
      logic [2:0]  sbaccess;
      logic        sbautoincrement;
      logic        sbreadondata;
      logic [2:0]  sberror;
      logic [11:0] zero_lo;
   } sbcs_t;

   typedef struct packed {
      logic        haltreq;
      logic        resumereq;
      logic [28:0] reserved;
      logic        dmactive;
   } dmcontrol_t;

   // One DMI write word, read as SBCS or as DMCONTROL
   typedef union packed {
      sbcs_t      sbcs;
      dmcontrol_t dmcontrol;
   } dmi_word_u;

   // Unit that handles a request
   typedef enum logic [1:0] {
      target_none = 2'd0,
      target_sba  = 2'd1,
      target_hart = 2'd2
   } dmi_target_e;

   localparam logic [15:0] csr_dpc           = 16'h07b1;
   localparam logic [2:0]  cmderr_haltresume = 3'd4;

   // Abstract command and ABSTRACTCS field positions
   localparam int cmd_transfer_bit = 17;
   localparam int cmd_write_bit    = 16;
   localparam int cmderr_lsb       = 8;

   // Status word constants
   localparam logic [3:0] dm_version   = 4'd2;
   localparam logic [3:0] dm_datacount = 4'd1;

endpackage

/* src/dmi_front.sv */
`timescale 1ns/100ps

module dmi_front import dm_regs_pkg::*; #(
   parameter int credit_count = 2
) (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic        dmi_req_valid_i,
   input  dmi_addr_t   dmi_req_addr_i,
   input  logic        dmi_req_write_i,
   input  logic [31:0] dmi_req_data_i,
   input  logic        sb_busy_i,
   output logic        dmi_credit_o,
   output logic        disp_valid_o,
   output dmi_target_e disp_target_o,
   output dmi_addr_t   disp_addr_o,
   output logic        disp_write_o,
   output logic [31:0] disp_data_o
);

   localparam int ptr_w = (credit_count > 1) ? $clog2(credit_count) : 1;
   localparam int cnt_w = $clog2(credit_count + 1);

   dmi_target_e      target_q [credit_count];
   dmi_addr_t        addr_q [credit_count];
   logic             write_q [credit_count];
   logic [31:0]      data_q [credit_count];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   dmi_target_e      req_target;
   logic             head_blocked;

   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(credit_count - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // Route by address range
   always_comb begin
      if (dmi_req_addr_i >= dm_data0 && dmi_req_addr_i <= dm_command) begin
         req_target = target_hart;
      end else if (dmi_req_addr_i >= dm_sbcs && dmi_req_addr_i <= dm_sbdata0) begin
         req_target = target_sba;
      end else begin
         req_target = target_none;
      end
   end

   // The requester never sends without a credit, so a slot is always free
   always_ff @(posedge clk_sys) begin
      if (dmi_req_valid_i) begin
         target_q[wr_ptr] <= req_target;
         addr_q[wr_ptr]   <= dmi_req_addr_i;
         write_q[wr_ptr]  <= dmi_req_write_i;
         data_q[wr_ptr]   <= dmi_req_data_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (dmi_req_valid_i) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (disp_valid_o) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({dmi_req_valid_i, disp_valid_o})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Bus requests wait at the head while an access is in flight
   assign head_blocked  = (target_q[rd_ptr] == target_sba) && sb_busy_i;
   assign disp_valid_o  = (count != '0) && !head_blocked;
   assign dmi_credit_o  = disp_valid_o;

   assign disp_target_o = target_q[rd_ptr];
   assign disp_addr_o   = addr_q[rd_ptr];
   assign disp_write_o  = write_q[rd_ptr];
   assign disp_data_o   = data_q[rd_ptr];

endmodule

/* src/dmi_resp_merge.sv */
`timescale 1ns/100ps

module dmi_resp_merge import dm_regs_pkg::*, sys_bus_pkg::*; (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic        disp_valid_i,
   input  dmi_addr_t   disp_addr_i,
   input  logic        disp_write_i,
   input  logic        sb_busy_i,
   input  logic [31:0] sbcs_i,
   input  sb_addr_t    sbaddress_i,
   input  sb_data_t    sbdata_i,
   input  logic        hart_halted_i,
   input  logic [31:0] data0_i,
   input  logic [31:0] dmcontrol_i,
   input  logic [2:0]  cmderr_i,
   output logic        dmi_rsp_valid_o,
   output logic [31:0] dmi_rsp_data_o
);

   logic [31:0] dmstatus;
   logic [31:0] abstractcs;
   logic [31:0] rd_data;
   sbcs_t       sbcs_live;

   // Single hart, always authenticated
   always_comb begin
      dmstatus       = '0;
      dmstatus[3:0]  = dm_version;
      dmstatus[7]    = 1'b1;
      dmstatus[8]    = hart_halted_i;
      dmstatus[9]    = hart_halted_i;
      dmstatus[10]   = !hart_halted_i;
      dmstatus[11]   = !hart_halted_i;
   end

   always_comb begin
      abstractcs                       = '0;
      abstractcs[3:0]                  = dm_datacount;
      abstractcs[cmderr_lsb +: 3]      = cmderr_i;
   end

   always_comb begin
      sbcs_live        = sbcs_i;
      sbcs_live.sbbusy = sb_busy_i;
   end

   always_comb begin
      case (disp_addr_i)
         dm_data0:      rd_data = data0_i;
         dm_dmcontrol:  rd_data = dmcontrol_i;
         dm_dmstatus:   rd_data = dmstatus;
         dm_abstractcs: rd_data = abstractcs;
         dm_sbcs:       rd_data = sbcs_live;
         dm_sbaddress0: rd_data = sbaddress_i;
         dm_sbdata0:    rd_data = sbdata_i;
         default:       rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         dmi_rsp_valid_o <= 1'b0;
      end else begin
         dmi_rsp_valid_o <= disp_valid_i;
      end
   end

   // Writes answer with zero
   always_ff @(posedge clk_sys) begin
      if (disp_valid_i) begin
         dmi_rsp_data_o <= disp_write_i ? '0 : rd_data;
      end
   end

endmodule

/* src/hart_ctl.sv */
`timescale 1ns/100ps

module hart_ctl import dm_regs_pkg::*; (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic        disp_valid_i,
   input  dmi_target_e disp_target_i,
   input  dmi_addr_t   disp_addr_i,
   input  logic        disp_write_i,
   input  logic [31:0] disp_data_i,
   output logic        hart_halted_o,
   output logic        hart_resume_o,
   output logic [31:0] hart_pc_o,
   output logic [31:0] data0_o,
   output logic [31:0] dmcontrol_o,
   output logic [2:0]  cmderr_o
);

   dmi_word_u   wr_word;
   logic        wr_sel;
   logic        wr_dmcontrol;
   logic        wr_data0;
   logic        wr_command;
   logic        wr_abstractcs;
   logic        cmd_dpc_write;

   logic        halted_q;
   logic        resume_q;
   logic [31:0] pc_q;
   logic [31:0] dpc_q;
   logic [31:0] data0_q;
   logic [2:0]  cmderr_q;
   dmcontrol_t  dmcontrol_q;

   assign wr_word       = disp_data_i;
   assign wr_sel        = disp_valid_i && (disp_target_i == target_hart) && disp_write_i;
   assign wr_dmcontrol  = wr_sel && (disp_addr_i == dm_dmcontrol);
   assign wr_data0      = wr_sel && (disp_addr_i == dm_data0);
   assign wr_command    = wr_sel && (disp_addr_i == dm_command);
   assign wr_abstractcs = wr_sel && (disp_addr_i == dm_abstractcs);

   // Access register command, write of DPC
   assign cmd_dpc_write = (disp_data_i[15:0] == csr_dpc)
                          && disp_data_i[cmd_transfer_bit]
                          && disp_data_i[cmd_write_bit];

   always_ff @(posedge clk_sys) begin
      if (wr_data0) begin
         data0_q <= disp_data_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         halted_q    <= 1'b0;
         resume_q    <= 1'b0;
         pc_q        <= '0;
         dpc_q       <= '0;
         cmderr_q    <= '0;
         dmcontrol_q <= '0;
      end else begin
         resume_q <= 1'b0;
         if (wr_dmcontrol) begin
            dmcontrol_q.haltreq  <= wr_word.dmcontrol.haltreq;
            dmcontrol_q.dmactive <= wr_word.dmcontrol.dmactive;
            // Haltreq wins over resumereq
            if (wr_word.dmcontrol.haltreq) begin
               halted_q <= 1'b1;
            end else if (wr_word.dmcontrol.resumereq && halted_q) begin
               halted_q <= 1'b0;
               resume_q <= 1'b1;
               pc_q     <= dpc_q;
            end
         end
         if (wr_command) begin
            if (halted_q && cmd_dpc_write) begin
               dpc_q <= data0_q;
            end else begin
               cmderr_q <= cmderr_haltresume;
            end
         end
         if (wr_abstractcs) begin
            cmderr_q <= cmderr_q & ~disp_data_i[cmderr_lsb +: 3];
         end
      end
   end

   assign hart_halted_o = halted_q;
   assign hart_resume_o = resume_q;
   assign hart_pc_o     = pc_q;
   assign data0_o       = data0_q;
   assign dmcontrol_o   = dmcontrol_q;
   assign cmderr_o      = cmderr_q;

endmodule

/* src/sba_engine.sv */
`timescale 1ns/100ps

module sba_engine import dm_regs_pkg::*, sys_bus_pkg::*; #(
   parameter int mem_words = 256
) (
   input  logic                         clk_sys,
   input  logic                         reset_i,
   input  logic                         disp_valid_i,
   input  dmi_target_e                  disp_target_i,
   input  dmi_addr_t                    disp_addr_i,
   input  logic                         disp_write_i,
   input  logic [31:0]                  disp_data_i,
   input  sb_data_t                     mem_rdata_i,
   output logic                         sb_busy_o,
   output logic [31:0]                  sbcs_o,
   output sb_addr_t                     sbaddress_o,
   output sb_data_t                     sbdata_o,
   output logic                         mem_en_o,
   output logic                         mem_we_o,
   output logic [$clog2(mem_words)-1:0] mem_addr_o,
   output sb_data_t                     mem_wdata_o
);

   localparam int       mem_aw     = $clog2(mem_words);
   localparam sb_addr_t addr_limit = sb_addr_t'(mem_words * 4);

   dmi_word_u  wr_word;
   sbcs_t      sbcs_view;
   logic       sel;
   logic       wr_sbcs;
   logic       wr_addr;
   logic       wr_data;
   logic       rd_data;
   logic       start;
   logic       bad_addr;
   sb_addr_t   start_addr;

   logic       readonaddr_q;
   logic       autoinc_q;
   logic       readondata_q;
   logic [2:0] access_q;
   logic [2:0] sberror_q;
   logic       busy_q;
   logic       phase_q;
   logic       op_write_q;
   sb_addr_t   addr_q;
   sb_data_t   data_q;

   assign wr_word = disp_data_i;
   assign sel     = disp_valid_i && (disp_target_i == target_sba);
   assign wr_sbcs = sel && disp_write_i && (disp_addr_i == dm_sbcs);
   assign wr_addr = sel && disp_write_i && (disp_addr_i == dm_sbaddress0);
   assign wr_data = sel && disp_write_i && (disp_addr_i == dm_sbdata0);
   assign rd_data = sel && !disp_write_i && (disp_addr_i == dm_sbdata0);

   // Access triggers, a new address takes effect for read-on-address
   assign start      = wr_data || (wr_addr && readonaddr_q) || (rd_data && readondata_q);
   assign start_addr = wr_addr ? disp_data_i : addr_q;
   assign bad_addr   = start_addr >= addr_limit;

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         readonaddr_q <= 1'b0;
         access_q     <= sb_access_32;
         autoinc_q    <= 1'b0;
         readondata_q <= 1'b0;
         sberror_q    <= sb_err_none;
         busy_q       <= 1'b0;
         phase_q      <= 1'b0;
         op_write_q   <= 1'b0;
      end else begin
         if (wr_sbcs) begin
            readonaddr_q <= wr_word.sbcs.sbreadonaddr;
            access_q     <= wr_word.sbcs.sbaccess;
            autoinc_q    <= wr_word.sbcs.sbautoincrement;
            readondata_q <= wr_word.sbcs.sbreadondata;
            // Write 1 to clear
            sberror_q    <= sberror_q & ~wr_word.sbcs.sberror;
         end
         // Out of range accesses never reach the memory
         if (start && bad_addr) begin
            sberror_q <= sb_err_badaddr;
         end
         if (start && !bad_addr) begin
            busy_q     <= 1'b1;
            op_write_q <= wr_data;
         end else if (busy_q) begin
            // Two cycles, memory request then completion
            phase_q <= !phase_q;
            busy_q  <= !phase_q;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (wr_addr) begin
         addr_q <= disp_data_i;
      end else if (busy_q && phase_q && autoinc_q) begin
         addr_q <= addr_q + 32'd4;
      end
      if (wr_data) begin
         data_q <= disp_data_i;
      end else if (busy_q && phase_q && !op_write_q) begin
         data_q <= mem_rdata_i;
      end
   end

   assign mem_en_o    = busy_q && !phase_q;
   assign mem_we_o    = busy_q && !phase_q && op_write_q;
   assign mem_addr_o  = addr_q[mem_aw+1:2];
   assign mem_wdata_o = data_q;

   // Busy is merged in on the response path
   always_comb begin
      sbcs_view                 = '0;
      sbcs_view.sbreadonaddr    = readonaddr_q;
      sbcs_view.sbaccess        = access_q;
      sbcs_view.sbautoincrement = autoinc_q;
      sbcs_view.sbreadondata    = readondata_q;
      sbcs_view.sberror         = sberror_q;
   end

   assign sbcs_o      = sbcs_view;
   assign sb_busy_o   = busy_q;
   assign sbaddress_o = addr_q;
   assign sbdata_o    = data_q;

endmodule

/* src/sys_bus_pkg.sv */
package sys_bus_pkg;

   // Byte address and data of the system bus
   typedef logic [31:0] sb_addr_t;
   typedef logic [31:0] sb_data_t;

   // Access size code, only 32-bit accesses are handled
   localparam logic [2:0] sb_access_32 = 3'd2;

   // Bus error codes as reported in sberror
   localparam logic [2:0] sb_err_none    = 3'd0;
   localparam logic [2:0] sb_err_badaddr = 3'd2;

endpackage

/* tests/tb_dbg_preload.sv */
`timescale 1ns/100ps

module tb_dbg_preload import dm_regs_pkg::*; ();

   localparam int credit_count = 2;
   localparam int mem_words    = 256;
   localparam int wait_limit   = 200;

   logic        clk_sys;
   logic        reset_i;
   logic        dmi_req_valid_i;
   dmi_addr_t   dmi_req_addr_i;
   logic        dmi_req_write_i;
   logic [31:0] dmi_req_data_i;
   logic        dmi_credit_o;
   logic        dmi_rsp_valid_o;
   logic [31:0] dmi_rsp_data_o;
   logic        hart_halted_o;
   logic        hart_resume_o;
   logic [31:0] hart_pc_o;

   // Bookkeeping, edge counters are updated on the rising edge
   int          errors;
   int          timeouts;
   int          seed;
   int          sent;
   int          reqs_seen;
   int          credits_seen;
   int          resumes_seen;
   string       test_name;
   logic [31:0] exp_q[$];
   string       name_q[$];

   // Reference model state
   logic        m_readonaddr;
   logic        m_autoinc;
   logic        m_readondata;
   logic [2:0]  m_access;
   logic [2:0]  m_sberror;
   logic [31:0] m_addr;
   logic [31:0] m_data;
   logic [31:0] m_mem [mem_words];
   logic        m_halted;
   logic [31:0] m_pc;
   logic [31:0] m_dpc;
   logic [31:0] m_data0;
   logic [31:0] m_dmctl;
   logic [2:0]  m_cmderr;
   int          m_resumes;

   dbg_preload_top #(
      .credit_count (credit_count),
      .mem_words    (mem_words)
   ) i_dut (
      .clk_sys         (clk_sys),
      .reset_i         (reset_i),
      .dmi_req_valid_i (dmi_req_valid_i),
      .dmi_req_addr_i  (dmi_req_addr_i),
      .dmi_req_write_i (dmi_req_write_i),
      .dmi_req_data_i  (dmi_req_data_i),
      .dmi_credit_o    (dmi_credit_o),
      .dmi_rsp_valid_o (dmi_rsp_valid_o),
      .dmi_rsp_data_o  (dmi_rsp_data_o),
      .hart_halted_o   (hart_halted_o),
      .hart_resume_o   (hart_resume_o),
      .hart_pc_o       (hart_pc_o)
   );

   initial begin
      clk_sys = 1'b0;
      forever #50 clk_sys = ~clk_sys;
   end

   always @(posedge clk_sys) begin
      if (dmi_req_valid_i) reqs_seen <= reqs_seen + 1;
      if (dmi_credit_o) credits_seen <= credits_seen + 1;
      if (hart_resume_o) resumes_seen <= resumes_seen + 1;
   end

   // Responses come back in request order
   always @(posedge clk_sys) begin
      logic [31:0] exp;
      string       name;
      if (dmi_rsp_valid_o) begin
         if (exp_q.size() == 0) begin
            $display("Response arrived with no request outstanding");
            errors++;
         end else begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            check_value(name, exp, dmi_rsp_data_o);
         end
      end
   end

   credit_has_request: assert property (@(posedge clk_sys) disable iff (reset_i)
      dmi_credit_o |-> (reqs_seen != credits_seen))
      else begin
         $display("Credit returned without a queued request");
         errors++;
      end

   credit_limit: assert property (@(posedge clk_sys) disable iff (reset_i)
      (reqs_seen - credits_seen) <= credit_count)
      else begin
         $display("More requests outstanding than credits allow");
         errors++;
      end

   rsp_after_dispatch: assert property (@(posedge clk_sys) disable iff (reset_i)
      dmi_credit_o |=> dmi_rsp_valid_o)
      else begin
         $display("No response one cycle after dispatch");
         errors++;
      end

   rsp_has_dispatch: assert property (@(posedge clk_sys) disable iff (reset_i)
      dmi_rsp_valid_o |-> $past(dmi_credit_o))
      else begin
         $display("Response without a dispatch in the cycle before");
         errors++;
      end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else begin
         $display("Fail %s: expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   function automatic logic [31:0] sbcs_word(input logic roa, input logic [2:0] acc,
                                             input logic ai, input logic rod,
                                             input logic [2:0] err);
      return {11'd0, roa, acc, ai, rod, err, 12'd0};
   endfunction

   // One bus access at the current model address
   task automatic model_access(input logic is_write);
      if (m_addr >= 32'(mem_words * 4)) begin
         m_sberror = 3'd2;
      end else begin
         if (is_write) m_mem[m_addr[9:2]] = m_data;
         else m_data = m_mem[m_addr[9:2]];
         if (m_autoinc) m_addr = m_addr + 32'd4;
      end
   endtask

   task automatic model_request(input dmi_addr_t addr, input logic write,
                                input logic [31:0] data, output logic [31:0] rsp);
      rsp = '0;
      if (write) begin
         case (addr)
            dm_sbcs: begin
               m_readonaddr = data[20];
               m_access     = data[19:17];
               m_autoinc    = data[16];
               m_readondata = data[15];
               m_sberror    = m_sberror & ~data[14:12];
            end
            dm_sbaddress0: begin
               m_addr = data;
               if (m_readonaddr) model_access(1'b0);
            end
            dm_sbdata0: begin
               m_data = data;
               model_access(1'b1);
            end
            dm_dmcontrol: begin
               m_dmctl = {data[31], 30'd0, data[0]};
               if (data[31]) begin
                  m_halted = 1'b1;
               end else if (data[30] && m_halted) begin
                  m_halted = 1'b0;
                  m_pc     = m_dpc;
                  m_resumes++;
               end
            end
            dm_data0: m_data0 = data;
            dm_command: begin
               if (m_halted && data[15:0] == csr_dpc && data[17] && data[16]) m_dpc = m_data0;
               else m_cmderr = cmderr_haltresume;
            end
            dm_abstractcs: m_cmderr = m_cmderr & ~data[10:8];
            default: ;
         endcase
      end else begin
         case (addr)
            dm_data0:      rsp = m_data0;
            dm_dmcontrol:  rsp = m_dmctl;
            dm_dmstatus:   rsp = 32'h82 | (m_halted ? 32'h300 : 32'hc00);
            dm_abstractcs: rsp = {21'd0, m_cmderr, 8'h01};
            dm_sbcs: rsp = sbcs_word(m_readonaddr, m_access, m_autoinc, m_readondata, m_sberror);
            dm_sbaddress0: rsp = m_addr;
            dm_sbdata0: begin
               rsp = m_data;
               if (m_readondata) model_access(1'b0);
            end
            default: ;
         endcase
      end
   endtask

   task automatic wait_credit();
      int n;
      n = 0;
      while ((sent - credits_seen) >= credit_count && n < wait_limit && timeouts == 0) begin
         @(negedge clk_sys);
         n++;
      end
      if ((sent - credits_seen) >= credit_count && timeouts == 0) begin
         $display("Timeout: no DMI credit came back within %0d cycles", wait_limit);
         timeouts++;
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || sent != credits_seen) && n < wait_limit && timeouts == 0) begin
         @(negedge clk_sys);
         n++;
      end
      if ((exp_q.size() != 0 || sent != credits_seen) && timeouts == 0) begin
         $display("Timeout: responses still outstanding after %0d cycles", wait_limit);
         timeouts++;
      end
   endtask

   // Called on a falling edge, spends one credit
   task automatic send_req(input dmi_addr_t addr, input logic write, input logic [31:0] data);
      logic [31:0] rsp;
      wait_credit();
      if (timeouts == 0) begin
         model_request(addr, write, data, rsp);
         exp_q.push_back(rsp);
         name_q.push_back(test_name);
         dmi_req_valid_i = 1'b1;
         dmi_req_addr_i  = addr;
         dmi_req_write_i = write;
         dmi_req_data_i  = data;
         sent++;
         @(negedge clk_sys);
         dmi_req_valid_i = 1'b0;
      end
   endtask

   initial begin
      logic [31:0] base;
      logic [31:0] pc_set;
      logic [31:0] sbcs_rw;
      seed            = 49320;
      errors          = 0;
      timeouts        = 0;
      sent            = 0;
      reqs_seen       = 0;
      credits_seen    = 0;
      resumes_seen    = 0;
      m_readonaddr    = 1'b0;
      m_autoinc       = 1'b0;
      m_readondata    = 1'b0;
      m_access        = 3'd2;
      m_sberror       = 3'd0;
      m_halted        = 1'b0;
      m_pc            = '0;
      m_dpc           = '0;
      m_dmctl         = '0;
      m_cmderr        = '0;
      m_resumes       = 0;
      reset_i         = 1'b1;
      dmi_req_valid_i = 1'b0;
      dmi_req_addr_i  = '0;
      dmi_req_write_i = 1'b0;
      dmi_req_data_i  = '0;
      repeat (3) @(negedge clk_sys);
      reset_i = 1'b0;

      test_name = "reset";
      check_value("reset credit", 32'd0, {31'd0, dmi_credit_o});
      check_value("reset rsp valid", 32'd0, {31'd0, dmi_rsp_valid_o});
      check_value("reset resume", 32'd0, {31'd0, hart_resume_o});
      check_value("reset halted", 32'd0, {31'd0, hart_halted_o});

      // Back to back requests stall on credits
      test_name = "credits";
      repeat (4) send_req(dm_dmstatus, 1'b0, '0);
      send_req(7'h20, 1'b0, '0);
      drain();

      test_name = "preload burst";
      base = 32'h80;
      send_req(dm_sbcs, 1'b1, sbcs_word(1'b0, 3'd2, 1'b1, 1'b0, 3'd0));
      send_req(dm_sbaddress0, 1'b1, base);
      for (int i = 0; i < 8; i++) begin
         send_req(dm_sbdata0, 1'b1, $random(seed));
         send_req(dm_sbaddress0, 1'b0, '0);
      end
      sbcs_rw = sbcs_word(1'b1, 3'd2, 1'b1, 1'b1, 3'd0);
      send_req(dm_sbcs, 1'b1, sbcs_rw);
      send_req(dm_sbaddress0, 1'b1, base);
      for (int i = 0; i < 8; i++) begin
         send_req(dm_sbdata0, 1'b0, '0);
         send_req(dm_sbaddress0, 1'b0, '0);
      end
      send_req(dm_sbcs, 1'b0, '0);
      drain();

      test_name = "bad address";
      send_req(dm_sbcs, 1'b1, sbcs_word(1'b0, 3'd2, 1'b1, 1'b0, 3'd0));
      // Lands on the word read back below if the upper address bits were dropped
      send_req(dm_sbaddress0, 1'b1, 32'(mem_words * 4) + base + 32'd8);
      send_req(dm_sbdata0, 1'b1, $random(seed));
      send_req(dm_sbcs, 1'b0, '0);
      // Clear sberror and read one burst word back
      send_req(dm_sbcs, 1'b1, sbcs_word(1'b1, 3'd2, 1'b0, 1'b0, 3'd7));
      send_req(dm_sbaddress0, 1'b1, base + 32'd8);
      send_req(dm_sbdata0, 1'b0, '0);
      send_req(dm_sbcs, 1'b0, '0);
      drain();

      test_name = "halt dpc resume";
      send_req(dm_dmcontrol, 1'b1, 32'h8000_0001);
      drain();
      check_value("halted level", 32'd1, {31'd0, hart_halted_o});
      send_req(dm_dmstatus, 1'b0, '0);
      pc_set = $random(seed);
      send_req(dm_data0, 1'b1, pc_set);
      send_req(dm_command, 1'b1, {14'd0, 2'b11, csr_dpc});
      send_req(dm_dmcontrol, 1'b1, 32'h4000_0001);
      drain();
      check_value("resume pulses", 32'(m_resumes), 32'(resumes_seen));
      check_value("resume pc", m_pc, hart_pc_o);
      check_value("running level", 32'd0, {31'd0, hart_halted_o});
      send_req(dm_dmcontrol, 1'b0, '0);
      send_req(dm_dmstatus, 1'b0, '0);
      send_req(dm_data0, 1'b0, '0);
      drain();

      test_name = "command while running";
      send_req(dm_data0, 1'b1, $random(seed));
      send_req(dm_command, 1'b1, {14'd0, 2'b11, csr_dpc});
      send_req(dm_abstractcs, 1'b0, '0);
      send_req(dm_dmcontrol, 1'b1, 32'h8000_0001);
      send_req(dm_dmcontrol, 1'b1, 32'h4000_0001);
      drain();
      check_value("resume pulses", 32'(m_resumes), 32'(resumes_seen));
      check_value("pc kept", pc_set, hart_pc_o);
      send_req(dm_abstractcs, 1'b1, 32'h0000_0700);
      send_req(dm_abstractcs, 1'b0, '0);
      drain();

      if (exp_q.size() != 0 || reqs_seen != sent) begin
         $display("Request and response counts do not match at the end");
         errors++;
      end
      $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
